// File: src/alloc_pkg.sv
package alloc_pkg;

    // ========================================================================
    // Buffer geometry
    // ========================================================================

    // Bytes per buffer
    localparam int BUFFER_SIZE = 1024;

    // Largest frame in bytes
    localparam int MAX_FRAME_SIZE = 16384;

    // Per-buffer metadata width
    localparam int META_WID = 8;

    // ========================================================================
    // Types
    // ========================================================================

    // Bytes in last buffer of a frame, 0 means full buffer
    typedef logic [$clog2(BUFFER_SIZE)-1:0] buf_size_t;

    // Total frame bytes, must hold MAX_FRAME_SIZE itself
    typedef logic [$clog2(MAX_FRAME_SIZE+1)-1:0] frame_size_t;

    typedef logic [META_WID-1:0] meta_t;

    // Descriptor fields below the next pointer
    // Packed as {eof, size, meta, err}
    typedef logic [1+$bits(buf_size_t)+META_WID+1-1:0] desc_info_t;

    localparam int DESC_INFO_WID = $bits(desc_info_t);

endpackage

// File: src/alloc_free_list.sv
`timescale 1ns/1ps

module alloc_free_list #(
    parameter int PTR_WID = 8
) (
    input  logic               clk,
    input  logic               reset,
    output logic               init_done,
    // Allocation side
    output logic               alloc_valid,
    output logic [PTR_WID-1:0] alloc_ptr,
    input  logic               alloc_ready,
    // Recycle side
    input  logic               recycle_valid,
    input  logic [PTR_WID-1:0] recycle_ptr,
    output logic               recycle_ready
);

    localparam int DEPTH = 2**PTR_WID;

    typedef enum logic {
        INIT,
        READY
    } state_t;

    state_t state;

    // Pointer storage, one slot per pointer so pushes never overflow
    logic [PTR_WID-1:0] mem [DEPTH];
    logic [PTR_WID-1:0] wr_idx;
    logic [PTR_WID-1:0] rd_idx;
    // Entries in mem, head register not included
    logic [PTR_WID:0]   count;

    logic               push;
    logic [PTR_WID-1:0] push_ptr;
    logic               load_head;

    // Recycles are only taken once the fill sequence is over
    assign recycle_ready = init_done;

    // Fill counter during INIT, returned pointers afterwards
    assign push     = (state == INIT) || (recycle_valid && recycle_ready);
    assign push_ptr = (state == INIT) ? wr_idx : recycle_ptr;

    // Refill head register when empty or being popped
    assign load_head = (state == READY) && (count != '0) && (!alloc_valid || alloc_ready);

    // ========================================================================
    // Storage and head register
    // ========================================================================

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_idx] <= push_ptr;
        end
        // Registered head keeps alloc_ptr steady while valid
        if (load_head) begin
            alloc_ptr <= mem[rd_idx];
        end
    end

    // ========================================================================
    // Control
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= INIT;
            init_done   <= 1'b0;
            wr_idx      <= '0;
            rd_idx      <= '0;
            count       <= '0;
            alloc_valid <= 1'b0;
        end else begin
            // Last fill write, indices wrap back to 0
            if (state == INIT && (&wr_idx)) begin
                state     <= READY;
                init_done <= 1'b1;
            end

            if (push) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (load_head) begin
                rd_idx <= rd_idx + 1'b1;
            end
            count <= count + (PTR_WID+1)'(push) - (PTR_WID+1)'(load_head);

            // Head valid follows refill, drops on pop with nothing behind it
            if (load_head) begin
                alloc_valid <= 1'b1;
            end else if (alloc_ready) begin
                alloc_valid <= 1'b0;
            end
        end
    end

endmodule

// File: src/alloc_desc_mem.sv
`timescale 1ns/1ps

module alloc_desc_mem #(
    parameter int PTR_WID = 8
) (
    input  logic                                      clk,
    // Write port
    input  logic                                      desc_wr_en,
    input  logic [PTR_WID-1:0]                        desc_wr_addr,
    input  logic [PTR_WID+alloc_pkg::DESC_INFO_WID-1:0] desc_wr_data,
    // Read port
    input  logic                                      desc_rd_en,
    input  logic [PTR_WID-1:0]                        desc_rd_addr,
    output logic [PTR_WID+alloc_pkg::DESC_INFO_WID-1:0] desc_rd_data
);

    import alloc_pkg::*;

    // Next pointer plus descriptor info
    localparam int DESC_WID = PTR_WID + DESC_INFO_WID;

    // One descriptor per buffer pointer
    logic [DESC_WID-1:0] ram [2**PTR_WID];

    // Simple dual port, registered read for RAM inference
    always_ff @(posedge clk) begin
        if (desc_wr_en) begin
            ram[desc_wr_addr] <= desc_wr_data;
        end
        if (desc_rd_en) begin
            desc_rd_data <= ram[desc_rd_addr];
        end
    end

endmodule

// File: src/alloc_scatter.sv
`timescale 1ns/1ps

module alloc_scatter #(
    parameter int PTR_WID = 8
) (
    input  logic                                        clk,
    input  logic                                        reset,
    // Store port
    input  logic                                        store_valid,
    input  logic                                        store_eof,
    input  alloc_pkg::buf_size_t                        store_size,
    input  alloc_pkg::meta_t                            store_meta,
    input  logic                                        store_err,
    output logic                                        store_ready,
    output logic [PTR_WID-1:0]                          store_ptr,
    // Free list pop
    input  logic                                        alloc_valid,
    input  logic [PTR_WID-1:0]                          alloc_ptr,
    output logic                                        alloc_ready,
    // Descriptor write
    output logic                                        desc_wr_en,
    output logic [PTR_WID-1:0]                          desc_wr_addr,
    output logic [PTR_WID+alloc_pkg::DESC_INFO_WID-1:0] desc_wr_data,
    // Frame report
    output logic                                        frame_valid,
    output logic [PTR_WID-1:0]                          frame_ptr,
    output alloc_pkg::frame_size_t                      frame_size,
    output logic                                        frame_error,
    input  logic                                        frame_ready
);

    import alloc_pkg::*;

    // Pointer handed to the producer for the next beat
    logic               cur_valid;
    logic [PTR_WID-1:0] cur_ptr;

    // Frame in progress
    logic               sof;
    logic [PTR_WID-1:0] head_ptr;
    frame_size_t        size_acc;
    logic               err_acc;

    logic               store_acc;
    logic               pop;
    frame_size_t        beat_bytes;
    frame_size_t        size_sum;
    logic               err_sum;
    desc_info_t         info;

    // Needs a current pointer plus a successor for its link field
    assign store_ready = cur_valid && alloc_valid && !frame_valid;
    assign store_ptr   = cur_ptr;
    assign store_acc   = store_valid && store_ready;

    // Take a pointer when none is held or the held one is being used
    assign alloc_ready = !cur_valid || store_acc;
    assign pop         = alloc_valid && alloc_ready;

    // ========================================================================
    // Frame accounting
    // ========================================================================

    always_comb begin
        // Zero size on the last buffer means it is full
        if (store_eof && store_size != '0) begin
            beat_bytes = frame_size_t'(store_size);
        end else begin
            beat_bytes = frame_size_t'(BUFFER_SIZE);
        end
    end

    // First beat restarts the running totals
    assign size_sum = (sof ? frame_size_t'(0) : size_acc) + beat_bytes;
    assign err_sum  = (sof ? 1'b0 : err_acc) | store_err;

    // Descriptor is written in the accepting cycle, linked to the list head
    assign info         = {store_eof, store_size, store_meta, store_err};
    assign desc_wr_en   = store_acc;
    assign desc_wr_addr = cur_ptr;
    assign desc_wr_data = {alloc_ptr, info};

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_valid   <= 1'b0;
            sof         <= 1'b1;
            frame_valid <= 1'b0;
        end else begin
            if (pop) begin
                cur_valid <= 1'b1;
            end
            if (store_acc) begin
                sof <= store_eof;
            end
            // Report held until accepted, stores blocked meanwhile
            if (store_acc && store_eof) begin
                frame_valid <= 1'b1;
            end else if (frame_ready) begin
                frame_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_ptr <= alloc_ptr;
        end
        if (store_acc) begin
            if (sof) begin
                head_ptr <= cur_ptr;
            end
            size_acc <= size_sum;
            err_acc  <= err_sum;
            if (store_eof) begin
                frame_ptr   <= sof ? cur_ptr : head_ptr;
                frame_size  <= size_sum;
                frame_error <= err_sum;
            end
        end
    end

endmodule

// File: src/alloc_gather.sv
`timescale 1ns/1ps

module alloc_gather #(
    parameter int PTR_WID = 8
) (
    input  logic                                        clk,
    input  logic                                        reset,
    // Load port
    input  logic                                        load_valid,
    input  logic [PTR_WID-1:0]                          load_ptr,
    output logic                                        load_ready,
    // Descriptor read
    output logic                                        desc_rd_en,
    output logic [PTR_WID-1:0]                          desc_rd_addr,
    input  logic [PTR_WID+alloc_pkg::DESC_INFO_WID-1:0] desc_rd_data,
    // Buffer output
    output logic                                        buf_valid,
    output logic [PTR_WID-1:0]                          buf_ptr,
    output logic                                        buf_eof,
    output alloc_pkg::buf_size_t                        buf_size,
    output alloc_pkg::meta_t                            buf_meta,
    output logic                                        buf_err,
    input  logic                                        buf_ready,
    // Pointer return
    output logic                                        recycle_valid,
    output logic [PTR_WID-1:0]                          recycle_ptr,
    input  logic                                        recycle_ready
);

    import alloc_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT,
        PRESENT
    } state_t;

    state_t             state;
    logic [PTR_WID-1:0] nxt_ptr;
    logic [PTR_WID-1:0] rd_next;
    desc_info_t         rd_info;
    logic               load_acc;
    logic               buf_acc;

    // Descriptor word is {next pointer, info}
    assign {rd_next, rd_info} = desc_rd_data;

    assign load_acc = load_valid && load_ready;

    // Pointer goes back to the free list with the accepted buffer
    assign recycle_valid = buf_valid && buf_ready;
    assign recycle_ptr   = buf_ptr;
    assign buf_acc       = recycle_valid && recycle_ready;

    // ========================================================================
    // Chain walk FSM
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            load_ready <= 1'b0;
            desc_rd_en <= 1'b0;
            buf_valid  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (load_acc) begin
                        load_ready <= 1'b0;
                        desc_rd_en <= 1'b1;
                        state      <= READ;
                    end else begin
                        load_ready <= 1'b1;
                    end
                end
                // Read issued this cycle
                READ: begin
                    desc_rd_en <= 1'b0;
                    state      <= WAIT;
                end
                // Read data valid, latch into outputs
                WAIT: begin
                    buf_valid <= 1'b1;
                    state     <= PRESENT;
                end
                PRESENT: begin
                    if (buf_acc) begin
                        buf_valid <= 1'b0;
                        if (buf_eof) begin
                            load_ready <= 1'b1;
                            state      <= IDLE;
                        end else begin
                            desc_rd_en <= 1'b1;
                            state      <= READ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // Head pointer first, then follow links
        if (state == IDLE && load_acc) begin
            desc_rd_addr <= load_ptr;
        end else if (state == PRESENT && buf_acc && !buf_eof) begin
            desc_rd_addr <= nxt_ptr;
        end
        // Buffer outputs only change here, so they hold under back-pressure
        if (state == WAIT) begin
            buf_ptr <= desc_rd_addr;
            nxt_ptr <= rd_next;
            {buf_eof, buf_size, buf_meta, buf_err} <= rd_info;
        end
    end

endmodule

// File: src/alloc_sg_core.sv
`timescale 1ns/1ps

module alloc_sg_core #(
    parameter int PTR_WID = 8
) (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        init_done,
    // Store port
    input  logic                        store_valid,
    input  logic                        store_eof,
    input  alloc_pkg::buf_size_t        store_size,
    input  alloc_pkg::meta_t            store_meta,
    input  logic                        store_err,
    output logic                        store_ready,
    output logic [PTR_WID-1:0]          store_ptr,
    // Frame report
    output logic                        frame_valid,
    output logic [PTR_WID-1:0]          frame_ptr,
    output alloc_pkg::frame_size_t      frame_size,
    output logic                        frame_error,
    input  logic                        frame_ready,
    // Load port
    input  logic                        load_valid,
    input  logic [PTR_WID-1:0]          load_ptr,
    output logic                        load_ready,
    // Buffer output
    output logic                        buf_valid,
    output logic [PTR_WID-1:0]          buf_ptr,
    output logic                        buf_eof,
    output alloc_pkg::buf_size_t        buf_size,
    output alloc_pkg::meta_t            buf_meta,
    output logic                        buf_err,
    input  logic                        buf_ready
);

    import alloc_pkg::*;

    localparam int DESC_WID = PTR_WID + DESC_INFO_WID;

    // Free list to scatter
    logic                alloc_valid;
    logic [PTR_WID-1:0]  alloc_ptr;
    logic                alloc_ready;

    // Gather back to free list
    logic                recycle_valid;
    logic [PTR_WID-1:0]  recycle_ptr;
    logic                recycle_ready;

    // Descriptor RAM ports
    logic                desc_wr_en;
    logic [PTR_WID-1:0]  desc_wr_addr;
    logic [DESC_WID-1:0] desc_wr_data;
    logic                desc_rd_en;
    logic [PTR_WID-1:0]  desc_rd_addr;
    logic [DESC_WID-1:0] desc_rd_data;

    alloc_free_list #(.PTR_WID(PTR_WID)) free_list_i (.*);

    alloc_desc_mem #(.PTR_WID(PTR_WID)) desc_mem_i (.*);

    alloc_scatter #(.PTR_WID(PTR_WID)) scatter_i (.*);

    alloc_gather #(.PTR_WID(PTR_WID)) gather_i (.*);

endmodule

// File: test/alloc_sg_core_sva.sv
`timescale 1ns/1ps

module alloc_sg_core_sva #(
    parameter int PTR_WID = 8
) (
    input logic                   clk,
    input logic                   reset,
    input logic                   init_done,
    input logic                   store_ready,
    input logic                   frame_valid,
    input logic                   frame_ready,
    input logic [PTR_WID-1:0]     frame_ptr,
    input alloc_pkg::frame_size_t frame_size,
    input logic                   frame_error,
    input logic                   load_ready,
    input logic                   buf_valid,
    input logic                   buf_ready,
    input logic [PTR_WID-1:0]     buf_ptr,
    input logic                   buf_eof,
    input alloc_pkg::buf_size_t   buf_size,
    input alloc_pkg::meta_t       buf_meta,
    input logic                   buf_err,
    input logic                   alloc_valid,
    input logic                   recycle_valid,
    input logic                   recycle_ready
);

    // ========================================================================
    // Reset and start-up
    // ========================================================================

    // Control outputs low after a reset cycle
    reset_clears: assert property (@(posedge clk)
        reset |=> !(init_done || store_ready || frame_valid || load_ready || buf_valid
                    || alloc_valid || recycle_valid))
        else $error("control outputs not cleared by reset");

    // No stores before the free list is filled
    store_after_init: assert property (@(posedge clk) !init_done |-> !store_ready)
        else $error("store_ready high before init_done");

    // ========================================================================
    // Handshake stability
    // ========================================================================

    buf_stable: assert property (@(posedge clk) disable iff (reset)
        buf_valid && !buf_ready |=>
            buf_valid && $stable({buf_ptr, buf_eof, buf_size, buf_meta, buf_err}))
        else $error("buffer output changed while stalled");

    report_stable: assert property (@(posedge clk) disable iff (reset)
        frame_valid && !frame_ready |=>
            frame_valid && $stable({frame_ptr, frame_size, frame_error}))
        else $error("frame report changed before frame_ready");

    // Free list takes every returned pointer
    recycle_taken: assert property (@(posedge clk) disable iff (reset)
        recycle_valid |-> recycle_ready)
        else $error("recycle while the free list cannot take it");

    // One pointer return per accepted buffer
    recycle_once: assert property (@(posedge clk) disable iff (reset)
        recycle_valid |=> !recycle_valid)
        else $error("same buffer recycled twice");

endmodule

bind alloc_sg_core alloc_sg_core_sva #(.PTR_WID(PTR_WID)) sva_i (.*);

// File: test/alloc_sg_core_tb.sv
`timescale 1ns/1ps

module alloc_sg_core_tb;

    import alloc_pkg::*;

    localparam int PTR_WID = 4;
    localparam int NFRAMES = 6;

    // ========================================================================
    // Frame table
    // ========================================================================

    // Name, buffers, last size, first meta, err beat, hold, random stalls, frame size
    string names      [NFRAMES] = '{"single", "multi5", "err_flag", "held", "exhaust",
                                    "backpressure"};
    int    nbufs      [NFRAMES] = '{1, 5, 3, 3, 15, 4};
    int    last_sizes [NFRAMES] = '{300, 77, 0, 512, 1000, 64};
    int    first_meta [NFRAMES] = '{8'h5a, 8'h11, 8'h22, 8'h33, 8'h44, 8'h55};
    // Beat with err set, -1 for none
    int    err_beats  [NFRAMES] = '{-1, -1, 1, -1, -1, 3};
    // Held frame stays stored until the next frame drains the free list
    bit    holds      [NFRAMES] = '{0, 0, 0, 1, 0, 0};
    bit    stalls     [NFRAMES] = '{0, 0, 0, 0, 0, 1};
    int    exp_sizes  [NFRAMES] = '{300, 4173, 3072, 2560, 15336, 3136};

    logic               clk = 1'b0;
    logic               reset;
    logic               init_done;
    logic               store_valid, store_eof, store_err, store_ready;
    buf_size_t          store_size;
    meta_t              store_meta;
    logic [PTR_WID-1:0] store_ptr;
    logic               frame_valid, frame_error, frame_ready;
    logic [PTR_WID-1:0] frame_ptr;
    frame_size_t        frame_size;
    logic               load_valid, load_ready;
    logic [PTR_WID-1:0] load_ptr;
    logic               buf_valid, buf_eof, buf_err, buf_ready;
    logic [PTR_WID-1:0] buf_ptr;
    buf_size_t          buf_size;
    meta_t              buf_meta;

    // Free list model, FIFO order of the core
    logic [PTR_WID-1:0] free_q [$];
    logic [PTR_WID-1:0] cur_ptr;
    logic [PTR_WID-1:0] chain [NFRAMES][16];
    meta_t              metas [NFRAMES][16];
    int                 held = -1;
    int                 checks = 0;
    int                 errors = 0;
    int                 cycles = 0;

    alloc_sg_core #(.PTR_WID(PTR_WID)) dut_i (.*);

    always #20 clk = ~clk;

    // Fill, then 3 cycles per buffer with margin
    function automatic int cycle_limit();
        int total;
        total = 0;
        foreach (nbufs[i]) total += nbufs[i];
        return (2**PTR_WID + 3 * total) * 4 + 200;
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit()) begin
            $display("Timeout after %0d cycles, %0d checks, %0d errors", cycles, checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input string what, input int exp,
                               input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("[ERROR] %s %s: expected %0d, actual %0d", name, what, exp, act);
        end
    endtask

    // ========================================================================
    // Store, report and load
    // ========================================================================

    task automatic store_frame(input int f);
        int last;
        last = nbufs[f] - 1;
        for (int b = 0; b <= last; b++) begin
            // No successor pointer left, core has to stall
            if (free_q.size() == 0) begin
                // Nothing offered until pointers come back
                store_valid = 1'b0;
                repeat (4) begin
                    if (store_ready) begin
                        errors++;
                        $display("%s: store_ready high with the free list empty", names[f]);
                    end
                    step();
                end
                if (held < 0) begin
                    errors++;
                    $display("%s: free list empty and no stored frame to release", names[f]);
                end else begin
                    load_frame(held);
                    held = -1;
                end
            end
            store_valid = 1'b1;
            store_eof   = (b == last);
            store_size  = (b == last) ? buf_size_t'(last_sizes[f]) : '0;
            store_meta  = (b == 0) ? meta_t'(first_meta[f]) : meta_t'($urandom);
            store_err   = (b == err_beats[f]);
            metas[f][b] = store_meta;
            while (!store_ready) step();
            check_value(names[f], "store_ptr", int'(cur_ptr), int'(store_ptr));
            chain[f][b] = cur_ptr;
            cur_ptr     = free_q.pop_front();
            step();
        end
        store_valid = 1'b0;
    endtask

    task automatic accept_report(input int f);
        // Report due the cycle after the end-of-frame beat
        if (!frame_valid) begin
            errors++;
            $display("%s: no frame report after the end-of-frame beat", names[f]);
        end
        // Hold it back, stores stay blocked meanwhile
        repeat (3) begin
            if (store_ready) begin
                errors++;
                $display("%s: store_ready high while the report is pending", names[f]);
            end
            step();
        end
        check_value(names[f], "frame_ptr", int'(chain[f][0]), int'(frame_ptr));
        check_value(names[f], "frame_size", exp_sizes[f], int'(frame_size));
        check_value(names[f], "frame_error", int'(err_beats[f] >= 0), int'(frame_error));
        frame_ready = 1'b1;
        step();
        frame_ready = 1'b0;
    endtask

    task automatic load_frame(input int f);
        int last;
        int wait_cyc;
        last       = nbufs[f] - 1;
        load_valid = 1'b1;
        load_ptr   = chain[f][0];
        while (!load_ready) step();
        step();
        load_valid = 1'b0;
        for (int b = 0; b <= last; b++) begin
            // Read issue plus one cycle of RAM latency
            wait_cyc = 0;
            while (!buf_valid) begin
                step();
                wait_cyc++;
            end
            check_value(names[f], "buf_latency", 2, wait_cyc);
            buf_ready = stalls[f] ? 1'($urandom) : 1'b1;
            while (!buf_ready) begin
                step();
                buf_ready = 1'($urandom);
            end
            check_value(names[f], "buf_ptr", int'(chain[f][b]), int'(buf_ptr));
            check_value(names[f], "buf_eof", int'(b == last), int'(buf_eof));
            check_value(names[f], "buf_size", (b == last) ? last_sizes[f] : 0, int'(buf_size));
            check_value(names[f], "buf_meta", int'(metas[f][b]), int'(buf_meta));
            check_value(names[f], "buf_err", int'(b == err_beats[f]), int'(buf_err));
            step();
            buf_ready = 1'b0;
            // Recycled in chain order
            free_q.push_back(chain[f][b]);
        end
        check_value(names[f], "load_ready", 1, int'(load_ready));
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        int init_cyc;
        void'($urandom(32'hb7c9_0d40));
        reset       = 1'b1;
        store_valid = 1'b0;
        store_eof   = 1'b0;
        store_size  = '0;
        store_meta  = '0;
        store_err   = 1'b0;
        frame_ready = 1'b0;
        load_valid  = 1'b0;
        load_ptr    = '0;
        buf_ready   = 1'b0;
        for (int i = 0; i < 2**PTR_WID; i++) free_q.push_back(PTR_WID'(i));
        // Scatter keeps one pointer as current
        cur_ptr = free_q.pop_front();
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        // One fill write per cycle
        init_cyc = 0;
        while (!init_done) begin
            step();
            init_cyc++;
        end
        check_value("init", "init_cycles", 2**PTR_WID, init_cyc);
        for (int f = 0; f < NFRAMES; f++) begin
            store_frame(f);
            accept_report(f);
            if (holds[f]) begin
                held = f;
            end else begin
                load_frame(f);
            end
        end
        if (held >= 0) begin
            errors++;
            $display("%s: frame was never loaded, the free list never ran dry", names[held]);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: project.f
src/alloc_pkg.sv
src/alloc_free_list.sv
src/alloc_desc_mem.sv
src/alloc_scatter.sv
src/alloc_gather.sv
src/alloc_sg_core.sv
test/alloc_sg_core_sva.sv
test/alloc_sg_core_tb.sv

// File: Makefile
# Verilator build of the scatter-gather allocator testbench

.PHONY: compile run clean

compile:
	verilator --binary --assert -Wno-fatal --top-module alloc_sg_core_tb \
		-f project.f --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
